// File: run.sh
#!/usr/bin/env bash
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module cache_tb \
    -f sim.f \
    -o cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run failed with status $status"
    exit $status
fi

exit 0

// File: sim.f
verilog/cache_geom_pkg.sv
verilog/mem_bus_pkg.sv
verilog/line_merge.sv
verilog/tag_array.sv
verilog/data_array.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

// File: tb/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;
();

    localparam logic [31:0] SEED_INIT = 32'hc6d24f06;
    localparam int          NUM_REQ   = 600;
    localparam int          TIMEOUT   = 200;

    logic     clk;
    logic     rst_n;
    addr_t    addr;
    word_t    data_in;
    acc_len_t len;
    logic     valid_in;
    logic     write;
    logic     addr_ok;
    logic     data_ok;
    word_t    data_out;
    logic     r_req;
    addr_t    r_addr;
    logic     r_rdy;
    line_t    re_data;
    logic     re_valid;
    logic     w_req;
    addr_t    w_addr;
    line_t    w_data;
    logic     w_rdy;

    integer seed;
    int     cycle      = 0;
    int     reads_done = 0;
    int     writebacks = 0;

    // Golden byte image
    logic [7:0] gold [addr_t];

    // Reads in flight, oldest first
    word_t exp_q  [$];
    logic  fast_q [$];
    int    acc_q  [$];

    logic        have_last;
    logic [26:0] last_line;

    // Memory channel state seen one cycle earlier
    logic  w_stalled   = 1'b0;
    addr_t w_addr_held = '0;
    line_t w_data_held = '0;
    logic  r_stalled   = 1'b0;
    addr_t r_addr_held = '0;

    cache_top UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .data_in  (data_in),
        .len      (len),
        .valid_in (valid_in),
        .write    (write),
        .addr_ok  (addr_ok),
        .data_ok  (data_ok),
        .data_out (data_out),
        .r_req    (r_req),
        .r_addr   (r_addr),
        .r_rdy    (r_rdy),
        .re_data  (re_data),
        .re_valid (re_valid),
        .w_req    (w_req),
        .w_addr   (w_addr),
        .w_data   (w_data),
        .w_rdy    (w_rdy)
    );

    mem_model #(.SEED(SEED_INIT)) u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .w_req    (w_req),
        .w_addr   (w_addr),
        .w_data   (w_data),
        .w_rdy    (w_rdy),
        .r_req    (r_req),
        .r_addr   (r_addr),
        .r_rdy    (r_rdy),
        .re_data  (re_data),
        .re_valid (re_valid)
    );

    always #2 clk = !clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////
    // Golden model
    ////////////////////

    // Same fill as the backing memory
    function automatic logic [7:0] fill_byte(input addr_t a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic logic [7:0] gold_byte(input addr_t a);
        return gold.exists(a) ? gold[a] : fill_byte(a);
    endfunction

    function automatic word_t expected_word(input addr_t a);
        word_t w;
        int    off;
        w   = '0;
        off = int'(a[4:0]);
        for (int i = 0; i < 8; i++) begin
            // Past the line end reads as zero
            if (off + i < LINE_BYTES)
                w[8*i +: 8] = gold_byte({a[31:5], 5'b0} + addr_t'(off + i));
        end
        return w;
    endfunction

    function automatic line_t golden_line(input addr_t a);
        line_t l;
        for (int b = 0; b < LINE_BYTES; b++)
            l[8*b +: 8] = gold_byte({a[31:5], 5'b0} + addr_t'(b));
        return l;
    endfunction

    // 1 << len bytes from the offset, overflow dropped
    task automatic apply_write(input addr_t a, input word_t d, input acc_len_t l);
        int off;
        off = int'(a[4:0]);
        for (int i = 0; i < (1 << l); i++) begin
            if (off + i < LINE_BYTES)
                gold[{a[31:5], 5'b0} + addr_t'(off + i)] = d[8*i +: 8];
        end
    endtask

    // 4 tags x 4 sets, twice the cache capacity
    function automatic addr_t make_addr(input logic [1:0] tag_sel, input logic [1:0] set_sel,
                                        input offset_t off);
        return {tag_sel, 19'h12a4b, set_sel, 4'h9, off};
    endfunction

    ////////////////////
    // Checks
    ////////////////////

    task automatic abort_run(input string why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_val(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_channels();
        // No response while memory is busy
        if (w_req || r_req) begin
            check_val("data_ok", line_t'(data_ok), '0);
            check_val("addr_ok", line_t'(addr_ok), '0);
        end
        if (w_stalled) begin
            check_val("w_req", line_t'(w_req), line_t'(1'b1));
            check_val("w_addr", line_t'(w_addr), line_t'(w_addr_held));
            check_val("w_data", w_data, w_data_held);
        end
        if (r_stalled) begin
            check_val("r_req", line_t'(r_req), line_t'(1'b1));
            check_val("r_addr", line_t'(r_addr), line_t'(r_addr_held));
        end
        // Fetch targets the line of the missing request
        if (r_req && r_rdy)
            check_val("r_addr", line_t'(r_addr), line_t'({last_line, 5'b0}));
        // Dirty bytes must survive eviction
        if (w_req && w_rdy) begin
            check_val("w_addr offset", line_t'(w_addr[4:0]), '0);
            check_val("w_data", w_data, golden_line(w_addr));
            writebacks++;
        end
        w_stalled   = w_req && !w_rdy;
        w_addr_held = w_addr;
        w_data_held = w_data;
        r_stalled   = r_req && !r_rdy;
        r_addr_held = r_addr;
    endtask

    task automatic check_read();
        word_t exp;
        logic  fast;
        int    acc_cycle;
        if (exp_q.size() == 0) begin
            abort_run("data_ok raised with no read outstanding");
        end else begin
            exp       = exp_q.pop_front();
            fast      = fast_q.pop_front();
            acc_cycle = acc_q.pop_front();
            check_val("data_out", line_t'(data_out), line_t'(exp));
            if (fast)
                check_val("read hit latency", line_t'(cycle - acc_cycle), line_t'(1));
            reads_done++;
        end
    endtask

    // Sampled mid-cycle, away from the drive point
    always @(negedge clk) begin
        if (rst_n) begin
            check_channels();
            if (data_ok)
                check_read();
        end
    end

    ////////////////////
    // Driver
    ////////////////////

    task automatic send_request(input addr_t a, input word_t d, input acc_len_t l, input logic wr);
        int waited;
        waited   = 0;
        addr     = a;
        data_in  = d;
        len      = l;
        write    = wr;
        valid_in = 1'b1;
        @(negedge clk);
        while (!addr_ok && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!addr_ok) begin
            abort_run("request not accepted within 200 cycles");
        end else begin
            // Accepted at the coming edge
            if (wr) begin
                apply_write(a, d, l);
            end else begin
                exp_q.push_back(expected_word(a));
                // Same line as the last access must hit
                fast_q.push_back(have_last && a[31:5] == last_line);
                acc_q.push_back(cycle);
            end
            have_last = 1'b1;
            last_line = a[31:5];
            @(posedge clk);
            #1;
            valid_in = 1'b0;
        end
    endtask

    task automatic random_request();
        logic [31:0] r;
        word_t       d;
        r = $random(seed);
        d = {$random(seed), $random(seed)};
        // Occasional gap between requests
        if (r[15:13] == 3'd0) begin
            @(posedge clk);
            #1;
        end
        send_request(make_addr(r[1:0], r[3:2], r[8:4]), d, r[10:9], r[12:11] == 2'd0);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while ((exp_q.size() != 0 || !addr_ok) && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0 || !addr_ok)
            abort_run("cache did not return to idle within 200 cycles");
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        write     = 1'b0;
        addr      = '0;
        data_in   = '0;
        len       = LEN_1B;
        seed      = SEED_INIT;
        have_last = 1'b0;
        last_line = '0;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle outputs after reset
        @(negedge clk);
        check_val("addr_ok", line_t'(addr_ok), line_t'(1'b1));
        check_val("data_ok", line_t'(data_ok), '0);
        check_val("r_req", line_t'(r_req), '0);
        check_val("w_req", line_t'(w_req), '0);
        @(posedge clk);
        #1;

        for (int n = 0; n < NUM_REQ; n++)
            random_request();

        // Every line read back in 8-byte pieces
        for (int t = 0; t < 4; t++) begin
            for (int i = 0; i < 4; i++) begin
                for (int w = 0; w < 4; w++) begin
                    send_request(make_addr(2'(t), 2'(i), offset_t'(w * 8)), '0, LEN_8B, 1'b0);
                end
            end
        end

        wait_idle();
        $display("%0d reads and %0d write-backs checked", reads_done, writebacks);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;
#(
    parameter logic [31:0] SEED = 32'hc6d24f06
)
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    // Write-back channel
    input  wire logic  w_req,
    input  wire addr_t w_addr,
    input  wire line_t w_data,
    output logic       w_rdy,
    // Line fetch channel
    input  wire logic  r_req,
    input  wire addr_t r_addr,
    output logic       r_rdy,
    output line_t      re_data,
    output logic       re_valid
);

    // Bytes written back so far, the rest follow the fill pattern
    logic [7:0] mem [addr_t];

    integer seed;
    logic   w_busy;
    int     w_wait;
    logic   r_busy;
    int     r_wait;
    logic   ret_busy;
    int     ret_wait;
    addr_t  ret_addr;

    // Mixes every address bit into the top byte
    function automatic logic [7:0] fill_byte(input addr_t a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic line_t fetch_line(input addr_t base);
        line_t l;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (mem.exists(base + addr_t'(b)))
                l[8*b +: 8] = mem[base + addr_t'(b)];
            else
                l[8*b +: 8] = fill_byte(base + addr_t'(b));
        end
        return l;
    endfunction

    task automatic store_line(input addr_t base, input line_t l);
        for (int b = 0; b < LINE_BYTES; b++)
            mem[base + addr_t'(b)] = l[8*b +: 8];
    endtask

    ////////////////////
    // Ready and return timing
    ////////////////////

    task automatic step_outputs();
        w_rdy    = 1'b0;
        r_rdy    = 1'b0;
        re_valid = 1'b0;
        // Pending fetch counts down to its single return beat
        if (ret_busy) begin
            ret_wait--;
            if (ret_wait == 0) begin
                re_valid = 1'b1;
                re_data  = fetch_line(ret_addr);
                ret_busy = 1'b0;
            end
        end
        // 0 to 3 not-ready cycles per request
        if (rst_n && w_req) begin
            if (!w_busy) begin
                w_busy = 1'b1;
                w_wait = $random(seed) & 3;
            end
            if (w_wait == 0)
                w_rdy = 1'b1;
            else
                w_wait--;
        end
        if (rst_n && r_req) begin
            if (!r_busy) begin
                r_busy = 1'b1;
                r_wait = $random(seed) & 3;
            end
            if (r_wait == 0)
                r_rdy = 1'b1;
            else
                r_wait--;
        end
    endtask

    initial begin
        seed     = SEED;
        w_rdy    = 1'b0;
        r_rdy    = 1'b0;
        re_valid = 1'b0;
        re_data  = '0;
        w_busy   = 1'b0;
        r_busy   = 1'b0;
        ret_busy = 1'b0;
        w_wait   = 0;
        r_wait   = 0;
        ret_wait = 0;
        ret_addr = '0;
        forever begin
            @(negedge clk);
            // Handshakes that complete at the coming edge
            if (rst_n && w_req && w_rdy) begin
                store_line(w_addr, w_data);
                w_busy = 1'b0;
            end
            if (rst_n && r_req && r_rdy) begin
                ret_addr = r_addr;
                ret_wait = 1 + ($random(seed) & 3);
                ret_busy = 1'b1;
                r_busy   = 1'b0;
            end
            @(posedge clk);
            #1;
            step_outputs();
        end
    end

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    // Processor request
    input  wire addr_t    addr,
    input  wire word_t    data_in,
    input  wire acc_len_t len,
    input  wire logic     valid_in,
    input  wire logic     write,
    output logic          addr_ok,
    output logic          data_ok,
    // Memory channels
    input  wire logic     w_rdy,
    input  wire logic     r_rdy,
    input  wire logic     re_valid,
    input  wire line_t    re_data,
    output logic          w_req,
    output addr_t         w_addr,
    output line_t         w_data,
    output logic          r_req,
    output addr_t         r_addr,
    // Tag array
    input  wire tag_t     tag_rd0,
    input  wire tag_t     tag_rd1,
    input  wire logic [1:0] valid_rd,
    input  wire logic [1:0] dirty_rd,
    output index_t        arr_index,
    output logic [1:0]    tag_we,
    output tag_t          tag_wr,
    output logic          dirty_wr,
    // Data array
    input  wire line_t    line_rd0,
    input  wire line_t    line_rd1,
    output logic [1:0]    data_we,
    output byte_en_t      data_be,
    // Merge unit
    input  wire byte_en_t byte_en,
    output offset_t       req_offset,
    output acc_len_t      req_len,
    output word_t         req_data,
    output logic          req_write,
    output line_t         hit_line
);

    cache_state_t state;
    cache_state_t state_nx;

    addr_t      req_addr;
    tag_t       req_tag;
    index_t     req_index;
    logic       hit0;
    logic       hit1;
    logic       hit;
    logic       can_accept;
    logic       accept;
    logic       rand_bit;
    logic [1:0] victim_oh;

    // Lookup results kept for the later states
    logic [1:0] hit_hold;
    logic [1:0] dirty_hold;
    tag_t       tag_hold0;
    tag_t       tag_hold1;
    line_t      line_hold0;
    line_t      line_hold1;

    tag_t       victim_tag;
    logic       victim_dirty;
    line_t      victim_line;

    assign req_tag    = req_addr[ADDR_W-1 -: TAG_W];
    assign req_index  = req_addr[OFFS_W +: INDX_W];
    assign req_offset = req_addr[OFFS_W-1:0];

    ////////////////////
    // Hit detection
    ////////////////////

    assign hit0 = valid_rd[0] && (tag_rd0 == req_tag);
    assign hit1 = valid_rd[1] && (tag_rd1 == req_tag);
    assign hit  = hit0 || hit1;

    // Idle, or a read hit that frees the lookup stage
    assign can_accept = (state == S_IDLE) || (state == S_LOOKUP && hit && !req_write);
    assign accept     = valid_in && can_accept;
    assign addr_ok    = can_accept;

    // Read data on a hit or straight from the refill beat
    assign data_ok = (state == S_LOOKUP && hit && !req_write)
                  || (state == S_REFILL && re_valid && !req_write);

    // Next lookup index comes straight from the bus
    assign arr_index = can_accept ? addr[OFFS_W +: INDX_W] : req_index;

    ////////////////////
    // FSM
    ////////////////////

    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE: begin
                if (valid_in)
                    state_nx = S_LOOKUP;
            end
            S_LOOKUP: begin
                if (!hit)
                    state_nx = S_MISS;
                else if (req_write)
                    state_nx = S_WRITE;
                // Stay here for a pipelined read
                else if (!valid_in)
                    state_nx = S_IDLE;
            end
            S_MISS: begin
                // Clean victim skips the write-back
                if (w_rdy || !victim_dirty)
                    state_nx = S_REPLACE;
            end
            S_REPLACE: begin
                if (r_rdy)
                    state_nx = S_REFILL;
            end
            S_REFILL: begin
                if (re_valid)
                    state_nx = S_IDLE;
            end
            default: state_nx = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            rand_bit  <= 1'b0;
            req_write <= 1'b0;
        end else begin
            state <= state_nx;
            // Pseudo-random way pick
            if (state == S_LOOKUP)
                rand_bit <= !rand_bit;
            if (accept)
                req_write <= write;
        end
    end

    // Request payload and lookup snapshot
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= addr;
            req_data <= data_in;
            req_len  <= len;
        end
        if (state == S_LOOKUP) begin
            hit_hold   <= {hit1, hit0};
            dirty_hold <= dirty_rd;
            tag_hold0  <= tag_rd0;
            tag_hold1  <= tag_rd1;
            line_hold0 <= line_rd0;
            line_hold1 <= line_rd1;
        end
    end

    ////////////////////
    // Victim and arrays
    ////////////////////

    // Toggle is frozen once the lookup is left
    assign victim_oh    = {rand_bit, !rand_bit};
    assign victim_tag   = rand_bit ? tag_hold1 : tag_hold0;
    assign victim_dirty = dirty_hold[rand_bit];
    assign victim_line  = rand_bit ? line_hold1 : line_hold0;

    // Line fed to read path and merge
    always_comb begin
        case (state)
            S_LOOKUP: hit_line = hit1 ? line_rd1 : line_rd0;
            S_WRITE:  hit_line = hit_hold[1] ? line_hold1 : line_hold0;
            default:  hit_line = re_data;
        endcase
    end

    assign tag_wr = req_tag;

    always_comb begin
        tag_we   = 2'b00;
        data_we  = 2'b00;
        data_be  = '1;
        dirty_wr = 1'b0;
        if (state == S_WRITE) begin
            // Store hit, only the touched bytes
            tag_we   = hit_hold;
            data_we  = hit_hold;
            data_be  = byte_en;
            dirty_wr = 1'b1;
        end else if (state == S_REFILL && re_valid) begin
            // Whole line, store data already merged in
            tag_we   = victim_oh;
            data_we  = victim_oh;
            dirty_wr = req_write;
        end
    end

    ////////////////////
    // Memory channels
    ////////////////////

    assign w_req  = (state == S_MISS) && victim_dirty;
    assign w_addr = {victim_tag, req_index, {OFFS_W{1'b0}}};
    assign w_data = victim_line;

    assign r_req  = (state == S_REPLACE);
    assign r_addr = {req_tag, req_index, {OFFS_W{1'b0}}};

    // Fetch starts only once a pending write-back was taken
    a_one_channel: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(r_req) |-> !$past(w_req) || $past(w_rdy));

    // Write-back held until memory takes it
    a_wreq_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_req && !w_rdy |=> w_req && $stable(w_addr) && $stable(w_data));

    // Read data only right after an accept or on the refill beat
    a_data_ok_state: assert property (@(posedge clk) disable iff (!rst_n)
        data_ok |-> $past(accept) || re_valid);

endmodule

`default_nettype wire

// File: verilog/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    ////////////////////
    // Cache geometry
    ////////////////////

    // Byte offset inside a 32-byte line
    localparam int OFFS_W     = 5;
    // Set index, 64 sets
    localparam int INDX_W     = 6;
    // Remaining upper address bits
    localparam int TAG_W      = 21;
    localparam int NUM_SETS   = 64;
    localparam int NUM_WAYS   = 2;
    localparam int LINE_BYTES = 32;

    // Address fields
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDX_W-1:0]     index_t;
    typedef logic [OFFS_W-1:0]     offset_t;

    // One enable per byte of a line
    typedef logic [LINE_BYTES-1:0] byte_en_t;

    // Controller states
    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS,
        S_REPLACE,
        S_REFILL,
        S_WRITE
    } cache_state_t;

endpackage

`default_nettype wire

// File: verilog/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    // Processor side
    input  wire addr_t    addr,
    input  wire word_t    data_in,
    input  wire acc_len_t len,
    input  wire logic     valid_in,
    input  wire logic     write,
    output wire logic     addr_ok,
    output wire logic     data_ok,
    output wire word_t    data_out,
    // Memory read channel
    output wire logic     r_req,
    output wire addr_t    r_addr,
    input  wire logic     r_rdy,
    input  wire line_t    re_data,
    input  wire logic     re_valid,
    // Memory write channel
    output wire logic     w_req,
    output wire addr_t    w_addr,
    output wire line_t    w_data,
    input  wire logic     w_rdy
);

    index_t     arr_index;
    logic [1:0] tag_we;
    tag_t       tag_wr;
    logic       dirty_wr;
    tag_t       tag_rd0;
    tag_t       tag_rd1;
    logic [1:0] valid_rd;
    logic [1:0] dirty_rd;
    line_t      line_rd0;
    line_t      line_rd1;
    logic [1:0] data_we;
    byte_en_t   data_be;
    byte_en_t   byte_en;
    offset_t    req_offset;
    acc_len_t   req_len;
    word_t      req_data;
    logic       req_write;
    line_t      hit_line;
    line_t      merged;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .data_in    (data_in),
        .len        (len),
        .valid_in   (valid_in),
        .write      (write),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .w_rdy      (w_rdy),
        .r_rdy      (r_rdy),
        .re_valid   (re_valid),
        .re_data    (re_data),
        .w_req      (w_req),
        .w_addr     (w_addr),
        .w_data     (w_data),
        .r_req      (r_req),
        .r_addr     (r_addr),
        .tag_rd0    (tag_rd0),
        .tag_rd1    (tag_rd1),
        .valid_rd   (valid_rd),
        .dirty_rd   (dirty_rd),
        .arr_index  (arr_index),
        .tag_we     (tag_we),
        .tag_wr     (tag_wr),
        .dirty_wr   (dirty_wr),
        .line_rd0   (line_rd0),
        .line_rd1   (line_rd1),
        .data_we    (data_we),
        .data_be    (data_be),
        .byte_en    (byte_en),
        .req_offset (req_offset),
        .req_len    (req_len),
        .req_data   (req_data),
        .req_write  (req_write),
        .hit_line   (hit_line)
    );

    tag_array u_tags (
        .clk      (clk),
        .rst_n    (rst_n),
        .index    (arr_index),
        .tag_we   (tag_we),
        .tag_wr   (tag_wr),
        .dirty_wr (dirty_wr),
        .tag_rd0  (tag_rd0),
        .tag_rd1  (tag_rd1),
        .valid_rd (valid_rd),
        .dirty_rd (dirty_rd)
    );

    data_array u_data (
        .clk      (clk),
        .index    (arr_index),
        .we       (data_we),
        .be       (data_be),
        .wr_line  (merged),
        .rd_line0 (line_rd0),
        .rd_line1 (line_rd1)
    );

    // Read word and store merge on the selected line
    line_merge u_merge (
        .line_in (hit_line),
        .offset  (req_offset),
        .len     (req_len),
        .wdata   (req_data),
        .write   (req_write),
        .rd_word (data_out),
        .merged  (merged),
        .byte_en (byte_en)
    );

endmodule

`default_nettype wire

// File: verilog/data_array.sv
`timescale 1ns/1ps
`default_nettype none

module data_array
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire logic       clk,
    input  wire index_t     index,
    input  wire logic [1:0] we,
    input  wire byte_en_t   be,
    input  wire line_t      wr_line,
    output line_t           rd_line0,
    output line_t           rd_line1
);

    ////////////////////
    // Line storage
    ////////////////////

    line_t mem [NUM_WAYS][NUM_SETS];

    always_ff @(posedge clk) begin
        // Byte-granular write into the selected way
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (we[w] && be[b]) begin
                    mem[w][index][8*b +: 8] <= wr_line[8*b +: 8];
                end
            end
        end
        // Both ways read every cycle
        rd_line0 <= mem[0][index];
        rd_line1 <= mem[1][index];
    end

endmodule

`default_nettype wire

// File: verilog/line_merge.sv
`timescale 1ns/1ps
`default_nettype none

module line_merge
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire line_t    line_in,
    input  wire offset_t  offset,
    input  wire acc_len_t len,
    input  wire word_t    wdata,
    input  wire logic     write,
    output word_t         rd_word,
    output line_t         merged,
    output byte_en_t      byte_en
);

    byte_en_t len_mask;
    line_t    shifted;
    line_t    store_line;

    // Bytes above the line end shift in as zero
    assign shifted = line_in >> {offset, 3'b000};
    assign rd_word = shifted[WORD_W-1:0];

    always_comb begin
        case (len)
            LEN_1B:  len_mask = byte_en_t'(8'h01);
            LEN_2B:  len_mask = byte_en_t'(8'h03);
            LEN_4B:  len_mask = byte_en_t'(8'h0f);
            LEN_8B:  len_mask = byte_en_t'(8'hff);
            default: len_mask = '0;
        endcase
    end

    // Enables past byte 31 fall off the top
    assign byte_en    = write ? byte_en_t'(len_mask << offset) : '0;
    assign store_line = line_t'(wdata) << {offset, 3'b000};

    always_comb begin
        merged = line_in;
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (byte_en[b]) begin
                merged[8*b +: 8] = store_line[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 64;
    localparam int LINE_W = 256;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

    // Access length, bytes = 1 << code
    typedef logic [1:0] acc_len_t;

    localparam acc_len_t LEN_1B = 2'd0;
    localparam acc_len_t LEN_2B = 2'd1;
    localparam acc_len_t LEN_4B = 2'd2;
    localparam acc_len_t LEN_8B = 2'd3;

endpackage

`default_nettype wire

// File: verilog/tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module tag_array
    import cache_geom_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire index_t     index,
    input  wire logic [1:0] tag_we,
    input  wire tag_t       tag_wr,
    input  wire logic       dirty_wr,
    output tag_t            tag_rd0,
    output tag_t            tag_rd1,
    output logic [1:0]      valid_rd,
    output logic [1:0]      dirty_rd
);

    tag_t tag_mem [NUM_WAYS][NUM_SETS];

    // Status bits per way and set
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_bits;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_bits;

    // Tag words, read one cycle late
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tag_we[w])
                tag_mem[w][index] <= tag_wr;
        end
        tag_rd0 <= tag_mem[0][index];
        tag_rd1 <= tag_mem[1][index];
    end

    // Valid and dirty, all clear after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            valid_rd   <= '0;
            dirty_rd   <= '0;
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                // A written way becomes valid
                if (tag_we[w]) begin
                    valid_bits[w][index] <= 1'b1;
                    dirty_bits[w][index] <= dirty_wr;
                end
                valid_rd[w] <= valid_bits[w][index];
                dirty_rd[w] <= dirty_bits[w][index];
            end
        end
    end

    a_one_way: assert property (@(posedge clk) disable iff (!rst_n) tag_we != 2'b11);

endmodule

`default_nettype wire
